// ==== list.f ====
+incdir+include
hdl/nand_cpu_pkg.sv
hdl/nand_bus_pkg.sv
hdl/decoder.sv
hdl/alu.sv
hdl/reg_file.sv
hdl/fetch_unit.sv
hdl/mem_arbiter.sv
hdl/exec_ctrl.sv
hdl/nand_cpu_top.sv
tb/nand_cpu_tb_mem.sv
tb/nand_cpu_tb.sv

// ==== tb/nand_cpu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "nand_cpu_cfg.svh"

module nand_cpu_tb;

    localparam int NUM_TESTS = 5;

    logic                          clk = 1'b0;
    logic                          rst_n;
    logic [`NAND_CPU_AXI_AW-1:0]   awaddr, araddr, log_addr;
    logic [`NAND_CPU_AXI_DW-1:0]   wdata, rdata, log_data;
    logic [`NAND_CPU_AXI_DW/8-1:0] wstrb;
    logic [1:0]                    bresp, rresp;
    logic                          awvalid, awready, wvalid, wready, bvalid, bready;
    logic                          arvalid, arready, rvalid, rready, halted, log_valid;

    logic [7:0] image    [256];
    logic [7:0] exp_mem  [256];
    logic [7:0] exp_addr [$];
    logic [7:0] exp_data [$];
    int         errors = 0;
    int         writes = 0;
    int         failed_tests = 0;

    nand_cpu_top nand_cpu_top_inst (.*);

    nand_cpu_tb_mem mem_inst (.*);

    always #5 clk = ~clk;

    // Executes the image on the ISA rules until HLT
    function automatic void run_isa_model();
        logic [7:0] r [16];
        logic [7:0] pc;
        logic [7:0] next_pc;
        logic [7:0] ins;
        logic [7:0] a;
        logic [7:0] t;
        logic [3:0] k;
        logic       fl;
        for (int i = 0; i < 16; i++)
            r[i] = 8'h00;
        for (int i = 0; i < 256; i++)
            exp_mem[i] = image[i];
        pc = 8'h00;
        fl = 1'b0;
        exp_addr.delete();
        exp_data.delete();
        for (int step = 0; step < 2000; step++) begin
            ins     = exp_mem[pc];
            k       = ins[3:0];
            a       = r[0];
            t       = r[k];
            next_pc = pc + 8'd1;
            casez (ins)
                8'h00:        r[0] = 8'h00;
                8'b0000_????: r[k] = a;
                8'b0001_????: r[0] = ~(a & t);
                8'b0010_????: r[0] = a << t[2:0];
                8'b0011_????: r[0] = a >> t[2:0];
                8'b0100_????: fl = (a == t);
                8'b0101_????: fl = (a != t);
                8'b0110_????: if (fl) next_pc = t;
                8'b0111_????: begin
                    r[k]    = pc + 8'd1;
                    next_pc = t;
                end
                8'b10?1_????: r[0][7:4] = k;
                8'b10?0_????: r[0][3:0] = k;
                8'b1100_????: r[0] = exp_mem[t];
                8'b1101_????: begin
                    exp_mem[t] = a;
                    exp_addr.push_back(t);
                    exp_data.push_back(a);
                end
                8'b1110_????: begin
                    r[`NAND_CPU_TRAP_REG] = pc + 8'd1;
                    next_pc = {k, 4'h0};
                end
                default: return;   // HLT
            endcase
            pc = next_pc;
        end
    endfunction

    task automatic place_code(input int base, input int len, input logic [255:0] code);
        for (int i = 0; i < len; i++)
            image[base + i] = code[8*(len-1-i) +: 8];
    endtask

    task automatic build_program(input int num);
        for (int i = 0; i < 256; i++)
            image[i] = {4'hF, i[7:4] ^ i[3:0]};   // All HLT opcodes
        case (num)
            0: begin
                place_code(0, 32, {64'h00_9F_01_81_02_82_03_83, 64'h04_84_05_85_06_86_07_00,
                                   64'hD1_A5_93_D2_08_9C_8A_18, 64'hD3_00_83_09_9A_85_29_D4});
                place_code(32, 12, {64'h9A_85_39_D5_00_8E_0A_9F, 32'h8F_3A_D6_F0});
            end
            1: begin
                place_code(0, 21, {64'h00_9F_01_81_02_82_03_83, 64'h04_00_92_05_94_06_97_87,
                                   40'h07_47_65_D1_F0});
                place_code(8'h20, 12, {64'hD2_57_66_D3_80_47_66_D4, 32'h57_66_D1_F0});
                place_code(8'h40, 3, 24'h9A_D1_F0);
            end
            2: begin
                place_code(0, 19, {64'h00_9F_01_81_02_82_03_00, 64'h93_05_75_9F_8F_15_08_18,
                                   24'hD2_E5_F0});
                place_code(8'h30, 7, 56'h9F_8F_15_08_18_D1_75);   // Subroutine
                place_code(8'h50, 7, 56'h9F_8F_1F_08_18_D3_F0);   // INT 5 vector
            end
            3: place_code(0, 25, {64'h00_9F_01_81_02_00_9C_83, 64'hD1_00_C1_D2_9F_88_03_C3,
                                  64'hD1_9A_85_D3_C2_D1_C3_D2, 8'hF0});
            default: place_code(0, 9, 72'h00_9F_01_86_D1_F5_D1_D1_D1);
        endcase
    endtask

    task automatic run_program(input int num, input string name);
        int err_start;
        int seen;
        err_start = errors;
        @(posedge clk);
        rst_n <= 1'b0;
        @(posedge clk);
        build_program(num);
        for (int i = 0; i < 256; i++)
            mem_inst.mem[i] <= image[i];
        run_isa_model();
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        while (!halted)
            @(posedge clk);
        seen = writes;
        repeat (50) @(posedge clk);
        quiet_after_halt: assert (writes == seen) else begin
            $display("A memory write appeared after halted rose");
            errors++;
        end
        halt_held: assert (halted === 1'b1) else begin
            $display("halted fell again before the next reset");
            errors++;
        end
        all_stores: assert (exp_addr.size() == 0) else begin
            $display("%0d expected stores never reached memory", exp_addr.size());
            errors++;
        end
        for (int i = 0; i < 256; i++) begin
            mem_match: assert (mem_inst.mem[i] === exp_mem[i]) else begin
                $display("error: mem[%h] 0x%h expected 0x%h", i[7:0], mem_inst.mem[i], exp_mem[i]);
                errors++;
            end
        end
        if (errors == err_start) begin
            $display("test %0d (%s): ok", num, name);
        end else begin
            $display("test %0d (%s): %0d errors", num, name, errors - err_start);
            failed_tests++;
        end
    endtask

    // Byte map and lane 0 strobe on every offered address and write
    always @(posedge clk) begin
        if (wvalid) begin
            wstrb_ok: assert (wstrb == 4'b0001) else begin
                $display("error: wstrb 0x%h expected 0x1", wstrb);
                errors++;
            end
        end
        if (arvalid) begin
            araddr_ok: assert (araddr[1:0] == 2'b00 && araddr < 32'h400) else begin
                $display("error: araddr 0x%h is not a byte location times 4", araddr);
                errors++;
            end
        end
    end

    // Each logged write must be the next store of the model
    always @(posedge clk) begin
        if (log_valid) begin
            writes++;
            store_expected: assert (exp_addr.size() > 0) else begin
                $display("Write to awaddr 0x%h when no store was expected", log_addr);
                errors++;
            end
            if (exp_addr.size() > 0) begin
                addr_ok: assert (log_addr == ({24'd0, exp_addr[0]} << 2)) else begin
                    $display("error: awaddr 0x%h expected 0x%h", log_addr,
                             {24'd0, exp_addr[0]} << 2);
                    errors++;
                end
                data_ok: assert (log_data == {24'd0, exp_data[0]}) else begin
                    $display("error: wdata 0x%h expected 0x%h", log_data, {24'd0, exp_data[0]});
                    errors++;
                end
                void'(exp_addr.pop_front());
                void'(exp_data.pop_front());
            end
        end
    end

    initial begin
        repeat (20000 * NUM_TESTS) @(posedge clk);
        $display("Run timed out after %0d cycles", 20000 * NUM_TESTS);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        void'($urandom(10));
        rst_n = 1'b0;
        run_program(0, "alu ops");
        run_program(1, "compare and branch");
        run_program(2, "jrl and int");
        run_program(3, "load after store");
        run_program(4, "halt");
        $display("%0d tests, %0d failed, %0d errors", NUM_TESTS, failed_tests, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/nand_cpu_tb_mem.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "nand_cpu_cfg.svh"

module nand_cpu_tb_mem import nand_bus_pkg::*; (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [`NAND_CPU_AXI_AW-1:0]   awaddr,
    input  logic                          awvalid,
    output logic                          awready = 1'b0,
    input  logic [`NAND_CPU_AXI_DW-1:0]   wdata,
    input  logic [`NAND_CPU_AXI_DW/8-1:0] wstrb,
    input  logic                          wvalid,
    output logic                          wready = 1'b0,
    output logic [1:0]                    bresp = 2'b00,
    output logic                          bvalid = 1'b0,
    input  logic                          bready,
    input  logic [`NAND_CPU_AXI_AW-1:0]   araddr,
    input  logic                          arvalid,
    output logic                          arready = 1'b0,
    output logic [`NAND_CPU_AXI_DW-1:0]   rdata = '0,
    output logic [1:0]                    rresp = 2'b00,
    output logic                          rvalid = 1'b0,
    input  logic                          rready,
    output logic                          log_valid = 1'b0,
    output logic [`NAND_CPU_AXI_AW-1:0]   log_addr = '0,
    output logic [`NAND_CPU_AXI_DW-1:0]   log_data = '0
);

    logic [7:0]                    mem [256];   // Byte n at word address n*4
    logic                          got_aw;
    logic                          got_w;
    logic                          got_ar;
    logic [`NAND_CPU_AXI_AW-1:0]   waddr;
    logic [`NAND_CPU_AXI_AW-1:0]   raddr;
    logic [`NAND_CPU_AXI_DW-1:0]   wbuf;
    logic [`NAND_CPU_AXI_DW/8-1:0] wmask;
    int                            wdelay;
    int                            rdelay;

    always @(posedge clk) begin
        if (!rst_n) begin
            awready   <= 1'b0;
            wready    <= 1'b0;
            arready   <= 1'b0;
            bvalid    <= 1'b0;
            rvalid    <= 1'b0;
            got_aw    <= 1'b0;
            got_w     <= 1'b0;
            got_ar    <= 1'b0;
            log_valid <= 1'b0;
        end else begin
            log_valid <= 1'b0;
            awready   <= !got_aw && ($urandom % 4 != 0);   // Random stalls
            wready    <= !got_w && ($urandom % 4 != 0);
            arready   <= !got_ar && ($urandom % 4 != 0);
            if (awvalid && awready && !got_aw) begin
                got_aw <= 1'b1;
                waddr  <= awaddr;
                wdelay <= $urandom % 6;
            end
            if (wvalid && wready && !got_w) begin
                got_w <= 1'b1;
                wbuf  <= wdata;
                wmask <= wstrb;
            end
            if (got_aw && got_w && !bvalid) begin
                if (wdelay != 0) begin
                    wdelay <= wdelay - 1;
                end else begin
                    if (wmask[0])
                        mem[waddr[9:2]] <= wbuf[7:0];
                    bvalid    <= 1'b1;
                    bresp     <= OKAY;
                    log_valid <= 1'b1;   // One strobe per completed write
                    log_addr  <= waddr;
                    log_data  <= wbuf;
                end
            end
            if (bvalid && bready) begin
                bvalid <= 1'b0;
                got_aw <= 1'b0;
                got_w  <= 1'b0;
            end
            if (arvalid && arready && !got_ar) begin
                got_ar <= 1'b1;
                raddr  <= araddr;
                rdelay <= $urandom % 6;
            end
            if (got_ar && !rvalid) begin
                if (rdelay != 0) begin
                    rdelay <= rdelay - 1;
                end else begin
                    rvalid <= 1'b1;
                    rresp  <= OKAY;
                    rdata  <= {{(`NAND_CPU_AXI_DW-8){1'b0}}, mem[raddr[9:2]]};
                end
            end
            if (rvalid && rready) begin
                rvalid <= 1'b0;
                got_ar <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/nand_cpu_top.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "nand_cpu_cfg.svh"

module nand_cpu_top import nand_cpu_pkg::*; (
    input  logic                          clk,
    input  logic                          rst_n,
    output logic [`NAND_CPU_AXI_AW-1:0]   awaddr,
    output logic                          awvalid,
    input  logic                          awready,
    output logic [`NAND_CPU_AXI_DW-1:0]   wdata,
    output logic [`NAND_CPU_AXI_DW/8-1:0] wstrb,
    output logic                          wvalid,
    input  logic                          wready,
    input  logic [1:0]                    bresp,
    input  logic                          bvalid,
    output logic                          bready,
    output logic [`NAND_CPU_AXI_AW-1:0]   araddr,
    output logic                          arvalid,
    input  logic                          arready,
    input  logic [`NAND_CPU_AXI_DW-1:0]   rdata,
    input  logic [1:0]                    rresp,
    input  logic                          rvalid,
    output logic                          rready,
    output logic                          halted
);

    logic       instr_valid, instr_ready;
    logic [7:0] instr, instr_pc;
    exec_path_t path;
    mem_op_t    mem_op;
    alu_op_t    alu_op;
    logic       use_ra, use_rt, use_rw, use_rs, use_immdt, shift;
    logic       mem_access, jump, branch, interrupt, halt;
    logic [3:0] rt_addr, rw_addr, immdt, rf_w_addr;
    logic [7:0] ra, rt, alu_result, rf_w_data, redirect_pc;
    logic       alu_flag, rs, rf_we, flag_we, redirect;
    logic       f_req_valid, f_req_ready, f_resp_valid;
    logic [7:0] f_req_addr, d_req_addr, d_req_wdata, resp_data;
    logic       d_req_valid, d_req_ready, d_req_write, d_resp_valid, err;

    decoder decoder_inst (.*);

    alu alu_inst (
        .alu_op, .ra, .rt, .immdt, .shift, .result(alu_result), .flag(alu_flag)
    );

    reg_file reg_file_inst (
        .clk, .rst_n, .rt_addr, .we(rf_we), .w_addr(rf_w_addr), .w_data(rf_w_data),
        .flag_we, .flag_in(alu_flag), .ra, .rt, .flag(rs)
    );

    fetch_unit fetch_unit_inst (
        .clk, .rst_n, .redirect, .redirect_pc, .instr_valid, .instr_ready, .instr,
        .instr_pc, .req_valid(f_req_valid), .req_ready(f_req_ready),
        .req_addr(f_req_addr), .resp_valid(f_resp_valid), .resp_data
    );

    mem_arbiter mem_arbiter_inst (.*);

    exec_ctrl exec_ctrl_inst (.*);

endmodule

`default_nettype wire

// ==== hdl/exec_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "nand_cpu_cfg.svh"

module exec_ctrl import nand_cpu_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       instr_valid,
    output logic       instr_ready,
    input  logic [7:0] instr_pc,
    input  exec_path_t path,
    input  logic       use_ra,
    input  logic       use_rt,
    input  logic       use_rw,
    input  logic [3:0] rw_addr,
    input  logic       use_rs,
    input  logic       use_immdt,
    input  logic [3:0] immdt,
    input  logic       mem_access,
    input  mem_op_t    mem_op,
    input  logic       jump,
    input  logic       branch,
    input  logic       interrupt,
    input  logic       halt,
    input  logic [7:0] alu_result,
    input  logic       rs,
    input  logic [7:0] ra,
    input  logic [7:0] rt,
    output logic       rf_we,
    output logic [3:0] rf_w_addr,
    output logic [7:0] rf_w_data,
    output logic       flag_we,
    output logic       redirect,
    output logic [7:0] redirect_pc,
    output logic       d_req_valid,
    input  logic       d_req_ready,
    output logic [7:0] d_req_addr,
    output logic       d_req_write,
    output logic [7:0] d_req_wdata,
    input  logic       d_resp_valid,
    input  logic [7:0] resp_data,
    input  logic       err,
    output logic       halted
);

    typedef enum logic [1:0] {IDLE, MEM_WAIT, HALTED} state_t;

    state_t     state;
    logic       load_q;
    logic [3:0] load_addr_q;
    logic       accept;

    // A memory instruction is taken together with its data request
    assign instr_ready = (state == IDLE) && !err && (path != MEM || d_req_ready);
    assign accept      = instr_valid && instr_ready;
    assign d_req_valid = (state == IDLE) && instr_valid && mem_access && !err;
    assign d_req_addr  = rt;
    assign d_req_write = (mem_op == MEM_WRITE);
    assign d_req_wdata = use_ra ? ra : 8'h00;

    assign flag_we     = accept && use_rs;
    assign redirect    = accept && (jump || interrupt || (branch && rs));
    assign redirect_pc = use_immdt ? {immdt, 4'h0} : rt;  // INT vector or rk
    assign halted      = (state == HALTED);

    always_comb begin
        rf_we     = 1'b0;
        rf_w_addr = interrupt ? 4'(`NAND_CPU_TRAP_REG) : rw_addr;
        rf_w_data = alu_result;
        if (state == MEM_WAIT) begin
            rf_we     = d_resp_valid && load_q && !err;
            rf_w_addr = load_addr_q;
            rf_w_data = resp_data;
        end else if (accept && path != MEM) begin
            rf_we = use_rw || interrupt;
            if (jump || interrupt)
                rf_w_data = instr_pc + 8'd1;  // Return address
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state  <= IDLE;
            load_q <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (err)
                        state <= HALTED;
                    else if (accept && path == MEM) begin
                        state  <= MEM_WAIT;
                        load_q <= (mem_op == MEM_READ);
                    end else if (accept && halt)
                        state <= HALTED;
                end
                MEM_WAIT: begin
                    if (err)
                        state <= HALTED;
                    else if (d_resp_valid)
                        state <= IDLE;
                end
                default: state <= HALTED;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept)
            load_addr_q <= rw_addr;
    end

    halt_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        halted |=> halted && !(instr_valid && instr_ready));
    target_in_rt: assert property (@(posedge clk) disable iff (!rst_n)
        accept && (jump || branch || mem_access) |-> use_rt);

endmodule

`default_nettype wire

// ==== hdl/mem_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "nand_cpu_cfg.svh"

module mem_arbiter import nand_bus_pkg::*; #(
    parameter int AW = `NAND_CPU_AXI_AW,
    parameter int DW = `NAND_CPU_AXI_DW
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          f_req_valid,
    output logic          f_req_ready,
    input  logic [7:0]    f_req_addr,
    output logic          f_resp_valid,
    input  logic          d_req_valid,
    output logic          d_req_ready,
    input  logic [7:0]    d_req_addr,
    input  logic          d_req_write,
    input  logic [7:0]    d_req_wdata,
    output logic          d_resp_valid,
    output logic [7:0]    resp_data,
    output logic          err,
    output logic [AW-1:0] awaddr,
    output logic          awvalid,
    input  logic          awready,
    output logic [DW-1:0] wdata,
    output logic [DW/8-1:0] wstrb,
    output logic          wvalid,
    input  logic          wready,
    input  logic [1:0]    bresp,
    input  logic          bvalid,
    output logic          bready,
    output logic [AW-1:0] araddr,
    output logic          arvalid,
    input  logic          arready,
    input  logic [DW-1:0] rdata,
    input  logic [1:0]    rresp,
    input  logic          rvalid,
    output logic          rready
);

    grant_t     grant;
    logic       write_q;
    logic [7:0] addr_q;
    logic [7:0] wdata_q;
    logic       err_q;
    logic       d_take;
    logic       f_take;
    logic       rd_done;
    logic       wr_done;
    logic       bad;

    assign d_req_ready = (grant == GNT_NONE);
    assign f_req_ready = (grant == GNT_NONE) && !d_req_valid;  // Data wins
    assign d_take      = d_req_valid && d_req_ready;
    assign f_take      = f_req_valid && f_req_ready;

    assign rready  = (grant != GNT_NONE) && !write_q;
    assign bready  = (grant != GNT_NONE) && write_q;
    assign rd_done = rvalid && rready;
    assign wr_done = bvalid && bready;
    assign bad     = (rd_done && axi_resp_t'(rresp) != OKAY) ||
                     (wr_done && axi_resp_t'(bresp) != OKAY);
    assign err     = err_q || bad;

    assign f_resp_valid = rd_done && (grant == GNT_FETCH);
    assign d_resp_valid = (rd_done || wr_done) && (grant == GNT_DATA);
    assign resp_data    = rdata[7:0];

    // Byte n lives at word address n*4, lane 0
    assign awaddr = {{(AW-10){1'b0}}, addr_q, 2'b00};
    assign araddr = awaddr;
    assign wdata  = {{(DW-8){1'b0}}, wdata_q};
    assign wstrb  = {{(DW/8-1){1'b0}}, 1'b1};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            grant   <= GNT_NONE;
            write_q <= 1'b0;
            arvalid <= 1'b0;
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
            err_q   <= 1'b0;
        end else begin
            if (bad)
                err_q <= 1'b1;
            if (arready)
                arvalid <= 1'b0;
            if (awready)
                awvalid <= 1'b0;   // aw and w retire on their own
            if (wready)
                wvalid <= 1'b0;
            if (grant == GNT_NONE) begin
                if (d_take) begin
                    grant   <= GNT_DATA;
                    write_q <= d_req_write;
                    arvalid <= !d_req_write;
                    awvalid <= d_req_write;
                    wvalid  <= d_req_write;
                end else if (f_take) begin
                    grant   <= GNT_FETCH;
                    write_q <= 1'b0;
                    arvalid <= 1'b1;
                end
            end else if (rd_done || wr_done) begin
                grant <= GNT_NONE;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (d_take) begin
            addr_q  <= d_req_addr;
            wdata_q <= d_req_wdata;
        end else if (f_take) begin
            addr_q <= f_req_addr;
        end
    end

    ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid && !arready |=> arvalid && $stable(araddr));
    aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
        awvalid && !awready |=> awvalid && $stable(awaddr));
    w_hold: assert property (@(posedge clk) disable iff (!rst_n)
        wvalid && !wready |=> wvalid && $stable(wdata));
    one_resp: assert property (@(posedge clk) disable iff (!rst_n)
        !(f_resp_valid && d_resp_valid));

endmodule

`default_nettype wire

// ==== hdl/fetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "nand_cpu_cfg.svh"

module fetch_unit (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       redirect,
    input  logic [7:0] redirect_pc,
    output logic       instr_valid,
    input  logic       instr_ready,
    output logic [7:0] instr,
    output logic [7:0] instr_pc,
    output logic       req_valid,
    input  logic       req_ready,
    output logic [7:0] req_addr,
    input  logic       resp_valid,
    input  logic [7:0] resp_data
);

    localparam int DEPTH = `NAND_CPU_PREFETCH_DEPTH;
    localparam int PW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [7:0]    buf_instr [DEPTH];
    logic [7:0]    buf_pc    [DEPTH];
    logic [PW-1:0] head;
    logic [PW-1:0] tail;
    logic [PW:0]   count;
    logic [7:0]    fetch_pc;
    logic          pend;     // One read in flight
    logic          stale;    // In-flight read predates a redirect
    logic          issue;
    logic          push;
    logic          pop;

    assign instr_valid = (count != '0);
    assign instr       = buf_instr[head];
    assign instr_pc    = buf_pc[head];
    assign req_valid   = !pend && (count < (PW+1)'(DEPTH));
    assign req_addr    = fetch_pc;
    assign issue       = req_valid && req_ready;
    assign push        = resp_valid && !stale && !redirect;
    assign pop         = instr_valid && instr_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            head     <= '0;
            tail     <= '0;
            count    <= '0;
            fetch_pc <= 8'h00;
            pend     <= 1'b0;
            stale    <= 1'b0;
        end else begin
            if (issue)
                pend <= 1'b1;
            else if (resp_valid)
                pend <= 1'b0;
            if (redirect)
                stale <= (pend && !resp_valid) || issue;
            else if (resp_valid)
                stale <= 1'b0;
            if (redirect) begin  // Flush
                head     <= '0;
                tail     <= '0;
                count    <= '0;
                fetch_pc <= redirect_pc;
            end else begin
                if (issue)
                    fetch_pc <= fetch_pc + 8'd1;
                if (push)
                    tail <= (tail == PW'(DEPTH - 1)) ? '0 : tail + 1'b1;
                if (pop)
                    head <= (head == PW'(DEPTH - 1)) ? '0 : head + 1'b1;
                count <= count + (PW+1)'(push) - (PW+1)'(pop);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            buf_instr[tail] <= resp_data;
            buf_pc[tail]    <= fetch_pc - 8'd1;  // Pointer already advanced at issue
        end
    end

endmodule

`default_nettype wire

// ==== hdl/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [3:0] rt_addr,
    input  logic       we,
    input  logic [3:0] w_addr,
    input  logic [7:0] w_data,
    input  logic       flag_we,
    input  logic       flag_in,
    output logic [7:0] ra,
    output logic [7:0] rt,
    output logic       flag
);

    logic [7:0] regs [16];
    logic       rs_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= 8'h00;
            end
            rs_q <= 1'b0;
        end else begin
            if (we)
                regs[w_addr] <= w_data;
            if (flag_we)
                rs_q <= flag_in;
        end
    end

    assign ra   = regs[0];   // Accumulator
    assign rt   = regs[rt_addr];
    assign flag = rs_q;

endmodule

`default_nettype wire

// ==== hdl/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu import nand_cpu_pkg::*; (
    input  alu_op_t    alu_op,
    input  logic [7:0] ra,
    input  logic [7:0] rt,
    input  logic [3:0] immdt,
    input  logic       shift,
    output logic [7:0] result,
    output logic       flag
);

    always_comb begin
        case (alu_op)
            ALU_CL:   result = 8'h00;
            ALU_NAND: result = ~(ra & rt);
            ALU_LS:   result = ra << rt[2:0];
            ALU_RS:   result = ra >> rt[2:0];  // Logical
            ALU_LI: begin
                if (shift)
                    result = {immdt, ra[3:0]};
                else
                    result = {ra[7:4], immdt};
            end
            default:  result = ra;  // CP copies r0 out
        endcase
    end

    assign flag = (alu_op == ALU_NE) ? (ra != rt) : (ra == rt);

endmodule

`default_nettype wire

// ==== hdl/decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module decoder import nand_cpu_pkg::*; (
    input  logic [7:0] instr,
    output exec_path_t path,
    output logic       use_ra,
    output logic       use_rt,
    output logic [3:0] rt_addr,
    output logic       use_rw,
    output logic [3:0] rw_addr,
    output logic       use_rs,
    output logic       use_immdt,
    output logic [3:0] immdt,
    output logic       shift,
    output logic       mem_access,
    output mem_op_t    mem_op,
    output logic       jump,
    output logic       branch,
    output logic       interrupt,
    output logic       halt,
    output alu_op_t    alu_op
);

    always_comb begin
        path       = EX;
        use_ra     = 1'b0;
        use_rt     = 1'b0;
        rt_addr    = instr[3:0];
        use_rw     = 1'b0;
        rw_addr    = 4'd0;       // Accumulator unless the form says otherwise
        use_rs     = 1'b0;
        use_immdt  = 1'b0;
        immdt      = instr[3:0];
        shift      = instr[4];   // LI nibble select, instr[5] is ignored
        mem_access = 1'b0;
        mem_op     = MEM_READ;
        jump       = 1'b0;
        branch     = 1'b0;
        interrupt  = 1'b0;
        halt       = 1'b0;
        alu_op     = ALU_CL;
        priority casez (instr)
            8'b0000_0000: use_rw = 1'b1;  // CL
            8'b0000_????: begin  // CP
                use_ra  = 1'b1;
                use_rw  = 1'b1;
                rw_addr = instr[3:0];
                alu_op  = ALU_CP;
            end
            8'b0001_????, 8'b0010_????, 8'b0011_????: begin  // NND, LS, RS
                use_ra = 1'b1;
                use_rt = 1'b1;
                use_rw = 1'b1;
                alu_op = (instr[5:4] == 2'b01) ? ALU_NAND :
                         (instr[5:4] == 2'b10) ? ALU_LS : ALU_RS;
            end
            8'b010?_????: begin  // EQ, NE
                use_ra = 1'b1;
                use_rt = 1'b1;
                use_rs = 1'b1;
                alu_op = instr[4] ? ALU_NE : ALU_EQ;
            end
            8'b0110_????: begin  // BR
                path   = BR;
                use_rt = 1'b1;
                branch = 1'b1;
            end
            8'b0111_????: begin  // JRL
                path    = BR;
                use_rt  = 1'b1;
                use_rw  = 1'b1;
                rw_addr = instr[3:0];
                jump    = 1'b1;
            end
            8'b10??_????: begin  // LI
                use_ra    = 1'b1;
                use_rw    = 1'b1;
                use_immdt = 1'b1;
                alu_op    = ALU_LI;
            end
            8'b110?_????: begin  // LD, ST
                path       = MEM;
                use_ra     = instr[4];
                use_rt     = 1'b1;
                use_rw     = !instr[4];
                mem_access = 1'b1;
                mem_op     = instr[4] ? MEM_WRITE : MEM_READ;
            end
            8'b1110_????: begin  // INT
                path      = BR;
                use_immdt = 1'b1;
                interrupt = 1'b1;
            end
            8'b1111_????: begin  // HLT
                use_immdt = 1'b1;
                halt      = 1'b1;
            end
        endcase
    end

    // Control transfer kinds are exclusive
    ctrl_onehot: assert property (@(instr) $onehot0({jump, branch, interrupt, halt}));

endmodule

`default_nettype wire

// ==== hdl/nand_bus_pkg.sv ====
`default_nettype none

package nand_bus_pkg;

    typedef enum logic [1:0] {
        GNT_NONE,
        GNT_FETCH,
        GNT_DATA
    } grant_t;

    typedef enum logic [1:0] {
        OKAY,
        EXOKAY,
        SLVERR,
        DECERR
    } axi_resp_t;

endpackage

`default_nettype wire

// ==== hdl/nand_cpu_pkg.sv ====
`default_nettype none

package nand_cpu_pkg;

    typedef enum logic [2:0] {
        ALU_CL,     // Clear accumulator
        ALU_CP,     // Copy accumulator out
        ALU_NAND,
        ALU_LS,
        ALU_RS,
        ALU_EQ,
        ALU_NE,
        ALU_LI      // Nibble load
    } alu_op_t;

    typedef enum logic {
        MEM_READ,
        MEM_WRITE
    } mem_op_t;

    typedef enum logic [1:0] {
        EX,         // Retires from the ALU
        MEM,        // Waits on the data port
        BR          // May redirect fetch
    } exec_path_t;

endpackage

`default_nettype wire

// ==== include/nand_cpu_cfg.svh ====
`ifndef NAND_CPU_CFG_SVH
`define NAND_CPU_CFG_SVH

// AXI4-Lite port widths
`define NAND_CPU_AXI_AW 32
`define NAND_CPU_AXI_DW 32

`define NAND_CPU_PREFETCH_DEPTH 2

`define NAND_CPU_TRAP_REG 15   // Receives the INT return address

`endif
